// File: hdl/frontend_cfg_pkg.sv
/*
 * Fetch frontend configuration
 * Address width, reset fetch address and predictor table sizes
 */
`default_nettype none

package frontend_cfg_pkg;

  // address and instruction width
  localparam int unsigned XLEN = 32;

  // first fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0080;

  // branch history table, indexed by pc[5:2]
  localparam int unsigned BHT_ENTRIES  = 16;
  localparam int unsigned BHT_IDX_BITS = 4;

  // return address stack depth
  localparam int unsigned RAS_DEPTH = 4;

endpackage : frontend_cfg_pkg

`default_nettype wire

// File: hdl/riscv_cf_pkg.sv
/*
 * RISC-V control-flow definitions
 * Major opcodes seen by the pre-decoder, control-flow classes
 * and the link register numbers used for call/return detection
 */
`default_nettype none

package riscv_cf_pkg;

  // major opcodes that matter for fetch, everything else folds into OPC_OTHER
  typedef enum logic [6:0] {
    OPC_OTHER  = 7'b000_0000,
    OPC_BRANCH = 7'b110_0011,
    OPC_JALR   = 7'b110_0111,
    OPC_JAL    = 7'b110_1111
  } opcode_e;

  // control-flow class of one fetched word
  typedef enum logic [2:0] {
    CF_NONE   = 3'd0,
    CF_BRANCH = 3'd1,
    CF_JUMP   = 3'd2,
    CF_CALL   = 3'd3,
    CF_RETURN = 3'd4,
    CF_JALR   = 3'd5
  } cf_e;

  // link registers, x1 and x5
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_T0 = 5'd5;

endpackage : riscv_cf_pkg

`default_nettype wire

// File: hdl/instr_scan.sv
/*
 * Instruction pre-decoder
 * Classifies a 32-bit word as branch, jump, call, return or jalr
 * and extracts the sign-extended B-type or J-type offset
 */
`default_nettype none

module instr_scan (
  input  logic [frontend_cfg_pkg::XLEN-1:0] instr_i,
  output riscv_cf_pkg::cf_e                 cf_o,
  output logic [frontend_cfg_pkg::XLEN-1:0] imm_o
);

  import frontend_cfg_pkg::*;
  import riscv_cf_pkg::*;

  opcode_e         opc;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic            rd_link;
  logic            rs1_link;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  assign rd       = instr_i[11:7];
  assign rs1      = instr_i[19:15];
  assign rd_link  = (rd == REG_RA) || (rd == REG_T0);
  assign rs1_link = (rs1 == REG_RA) || (rs1 == REG_T0);

  // B-type offset, bit 0 always zero
  assign imm_b = {{(XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  // J-type offset
  assign imm_j = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // fold the major opcode onto the few values fetch cares about
  always_comb begin
    case (instr_i[6:0])
      OPC_BRANCH: opc = OPC_BRANCH;
      OPC_JAL:    opc = OPC_JAL;
      OPC_JALR:   opc = OPC_JALR;
      default:    opc = OPC_OTHER;
    endcase
  end

  always_comb begin
    cf_o  = CF_NONE;
    imm_o = '0;
    case (opc)
      OPC_BRANCH: begin
        cf_o  = CF_BRANCH;
        imm_o = imm_b;
      end
      OPC_JAL: begin
        // jal writing a link register is a call
        cf_o  = rd_link ? CF_CALL : CF_JUMP;
        imm_o = imm_j;
      end
      OPC_JALR: begin
        // register target is unknown here, so the offset points at the next word
        imm_o = XLEN'(4);
        if (rd_link) begin
          cf_o = CF_CALL;
        end else if (rs1_link && (rd == 5'd0)) begin
          cf_o = CF_RETURN;
        end else begin
          cf_o = CF_JALR;
        end
      end
      default: ;
    endcase
  end

endmodule : instr_scan

`default_nettype wire

// File: hdl/bht.sv
/*
 * Branch history table
 * Direct-mapped 2-bit saturating counters with a valid bit per entry,
 * combinational lookup and a registered update from the back end
 */
`default_nettype none

module bht (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic [frontend_cfg_pkg::BHT_IDX_BITS-1:0] lookup_idx_i,
  input  logic                                      update_valid_i,
  input  logic [frontend_cfg_pkg::XLEN-1:0]         update_pc_i,
  input  logic                                      update_taken_i,
  output logic                                      pred_valid_o,
  output logic                                      pred_taken_o
);

  import frontend_cfg_pkg::*;

  logic [BHT_ENTRIES-1:0]  valid_q;
  logic [1:0]              cnt_q [BHT_ENTRIES];
  logic [BHT_IDX_BITS-1:0] upd_idx;

  // word-aligned pc, skip the two low bits
  assign upd_idx = update_pc_i[BHT_IDX_BITS+1:2];

  // lookup, counter msb is the taken guess
  assign pred_valid_o = valid_q[lookup_idx_i];
  assign pred_taken_o = cnt_q[lookup_idx_i][1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (update_valid_i) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_valid_i) begin
      if (!valid_q[upd_idx]) begin
        // first outcome seeds a weak counter
        cnt_q[upd_idx] <= update_taken_i ? 2'd2 : 2'd1;
      end else if (update_taken_i && (cnt_q[upd_idx] != 2'd3)) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'd1;
      end else if (!update_taken_i && (cnt_q[upd_idx] != 2'd0)) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'd1;
      end
    end
  end

endmodule : bht

`default_nettype wire

// File: hdl/ras.sv
/*
 * Return address stack
 * Shift stack with entry 0 on top, oldest entry lost on overflow
 */
`default_nettype none

module ras (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              push_i,
  input  logic                              pop_i,
  input  logic [frontend_cfg_pkg::XLEN-1:0] push_addr_i,
  output logic                              top_valid_o,
  output logic [frontend_cfg_pkg::XLEN-1:0] top_addr_o
);

  import frontend_cfg_pkg::*;

  localparam int unsigned CNT_W = $clog2(RAS_DEPTH + 1);

  logic [XLEN-1:0]  stack_q [RAS_DEPTH];
  logic [CNT_W-1:0] cnt_q;

  assign top_valid_o = (cnt_q != '0);
  assign top_addr_o  = stack_q[0];

  // occupancy count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (push_i && pop_i) begin
      // top replaced, an empty stack gains one entry
      if (cnt_q == '0) begin
        cnt_q <= CNT_W'(1);
      end
    end else if (push_i) begin
      if (cnt_q != CNT_W'(RAS_DEPTH)) begin
        cnt_q <= cnt_q + CNT_W'(1);
      end
    end else if (pop_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - CNT_W'(1);
    end
  end

  // entries, bottom falls off when pushing into a full stack
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      if (!pop_i) begin
        for (int i = RAS_DEPTH - 1; i > 0; i--) begin
          stack_q[i] <= stack_q[i-1];
        end
      end
      stack_q[0] <= push_addr_i;
    end else if (pop_i && (cnt_q != '0)) begin
      for (int i = 0; i < RAS_DEPTH - 1; i++) begin
        stack_q[i] <= stack_q[i+1];
      end
    end
  end

endmodule : ras

`default_nettype wire

// File: hdl/fetch_ctrl.sv
/*
 * Fetch control
 * Owns the PC, the single-outstanding memory request FSM, next-PC
 * selection from the predictors and the one-deep entry register to decode
 */
`default_nettype none

module fetch_ctrl (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // instruction memory
  output logic                                      imem_req_valid_o,
  output logic [frontend_cfg_pkg::XLEN-1:0]         imem_req_addr_o,
  input  logic                                      imem_req_ready_i,
  input  logic                                      imem_rsp_valid_i,
  input  logic [frontend_cfg_pkg::XLEN-1:0]         imem_rsp_data_i,
  // pre-decode of the response word
  input  riscv_cf_pkg::cf_e                         cf_i,
  input  logic [frontend_cfg_pkg::XLEN-1:0]         imm_i,
  // predictors
  output logic [frontend_cfg_pkg::BHT_IDX_BITS-1:0] bht_idx_o,
  input  logic                                      bht_valid_i,
  input  logic                                      bht_taken_i,
  output logic                                      ras_push_o,
  output logic [frontend_cfg_pkg::XLEN-1:0]         ras_push_addr_o,
  output logic                                      ras_pop_o,
  input  logic                                      ras_valid_i,
  input  logic [frontend_cfg_pkg::XLEN-1:0]         ras_addr_i,
  // back end
  input  logic                                      redirect_valid_i,
  input  logic [frontend_cfg_pkg::XLEN-1:0]         redirect_pc_i,
  // decode
  output logic                                      fetch_valid_o,
  output logic [frontend_cfg_pkg::XLEN-1:0]         fetch_pc_o,
  output logic [frontend_cfg_pkg::XLEN-1:0]         fetch_instr_o,
  output logic                                      fetch_pred_taken_o,
  output logic [frontend_cfg_pkg::XLEN-1:0]         fetch_pred_pc_o,
  input  logic                                      fetch_ready_i
);

  import frontend_cfg_pkg::*;
  import riscv_cf_pkg::*;

  // IDLE no request out, WAIT response pending, DROP response to discard
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT,
    FETCH_DROP
  } fetch_state_e;

  fetch_state_e    state_q, state_d;
  logic [XLEN-1:0] pc_q, pc_d;
  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] target_pc;
  logic [XLEN-1:0] pred_pc;
  logic            pred_taken;
  logic            entry_free;
  logic            rsp_live;

  // ---------------------------------------------------------------------------
  // request side
  // ---------------------------------------------------------------------------
  // entry register empty next cycle
  assign entry_free       = !fetch_valid_o || fetch_ready_i;
  // no request while reset is held
  assign imem_req_valid_o = rst_ni && (state_q == FETCH_IDLE) && entry_free &&
                            !redirect_valid_i;
  // pc_q holds the outstanding address until its response comes back
  assign imem_req_addr_o  = pc_q;
  assign rsp_live = imem_rsp_valid_i && (state_q == FETCH_WAIT) && !redirect_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: if (imem_req_valid_o && imem_req_ready_i) state_d = FETCH_WAIT;
      FETCH_WAIT: begin
        if (imem_rsp_valid_i) begin
          state_d = FETCH_IDLE;
        end else if (redirect_valid_i) begin
          state_d = FETCH_DROP;
        end
      end
      FETCH_DROP: if (imem_rsp_valid_i) state_d = FETCH_IDLE;
      default:    state_d = FETCH_IDLE;
    endcase
  end

  // ---------------------------------------------------------------------------
  // prediction for the returning word
  // ---------------------------------------------------------------------------
  assign seq_pc          = pc_q + XLEN'(4);
  assign target_pc       = pc_q + imm_i;
  assign bht_idx_o       = pc_q[BHT_IDX_BITS+1:2];
  assign ras_push_addr_o = seq_pc;
  assign ras_push_o      = rsp_live && (cf_i == CF_CALL);
  assign ras_pop_o       = rsp_live && (cf_i == CF_RETURN);

  always_comb begin
    pred_taken = 1'b0;
    pred_pc    = seq_pc;
    case (cf_i)
      CF_BRANCH: begin
        // counter if trained, else backward taken
        pred_taken = bht_valid_i ? bht_taken_i : imm_i[XLEN-1];
        if (pred_taken) pred_pc = target_pc;
      end
      CF_JUMP, CF_CALL: begin
        pred_taken = 1'b1;
        pred_pc    = target_pc;
      end
      CF_RETURN: begin
        // empty stack falls through
        pred_taken = ras_valid_i;
        if (ras_valid_i) pred_pc = ras_addr_i;
      end
      default: ;
    endcase
  end

  // redirect wins over everything
  always_comb begin
    pc_d = pc_q;
    if (redirect_valid_i) begin
      pc_d = redirect_pc_i;
    end else if (rsp_live) begin
      pc_d = pred_pc;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= FETCH_IDLE;
      pc_q          <= RESET_PC;
      fetch_valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      if (redirect_valid_i) begin
        fetch_valid_o <= 1'b0;
      end else if (rsp_live) begin
        fetch_valid_o <= 1'b1;
      end else if (fetch_ready_i) begin
        fetch_valid_o <= 1'b0;
      end
    end
  end

  // entry payload, only written by a live response
  always_ff @(posedge clk_i) begin
    if (rsp_live) begin
      fetch_pc_o         <= pc_q;
      fetch_instr_o      <= imem_rsp_data_i;
      fetch_pred_taken_o <= pred_taken;
      fetch_pred_pc_o    <= pred_pc;
    end
  end

endmodule : fetch_ctrl

`default_nettype wire

// File: hdl/frontend.sv
/*
 * Instruction fetch frontend, top level
 * Pre-decoder, history table and return stack feed fetch control
 */
`default_nettype none

module frontend (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // instruction memory
  output logic                              imem_req_valid_o,
  output logic [frontend_cfg_pkg::XLEN-1:0] imem_req_addr_o,
  input  logic                              imem_req_ready_i,
  input  logic                              imem_rsp_valid_i,
  input  logic [frontend_cfg_pkg::XLEN-1:0] imem_rsp_data_i,
  // decode
  output logic                              fetch_valid_o,
  output logic [frontend_cfg_pkg::XLEN-1:0] fetch_pc_o,
  output logic [frontend_cfg_pkg::XLEN-1:0] fetch_instr_o,
  output logic                              fetch_pred_taken_o,
  output logic [frontend_cfg_pkg::XLEN-1:0] fetch_pred_pc_o,
  input  logic                              fetch_ready_i,
  // back end
  input  logic                              redirect_valid_i,
  input  logic [frontend_cfg_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                              resolve_valid_i,
  input  logic [frontend_cfg_pkg::XLEN-1:0] resolve_pc_i,
  input  logic                              resolve_taken_i
);

  import frontend_cfg_pkg::*;
  import riscv_cf_pkg::*;

  cf_e                     scan_cf;
  logic [XLEN-1:0]         scan_imm;
  logic [BHT_IDX_BITS-1:0] bht_idx;
  logic                    bht_valid;
  logic                    bht_taken;
  logic                    ras_push;
  logic                    ras_pop;
  logic [XLEN-1:0]         ras_push_addr;
  logic                    ras_valid;
  logic [XLEN-1:0]         ras_addr;

  // pre-decode straight off the memory response
  instr_scan i_instr_scan (
    .instr_i (imem_rsp_data_i),
    .cf_o    (scan_cf),
    .imm_o   (scan_imm)
  );

  // both predictors answer in the response cycle
  bht i_bht (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lookup_idx_i   (bht_idx),
    .update_valid_i (resolve_valid_i),
    .update_pc_i    (resolve_pc_i),
    .update_taken_i (resolve_taken_i),
    .pred_valid_o   (bht_valid),
    .pred_taken_o   (bht_taken)
  );

  ras i_ras (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (ras_push),
    .pop_i       (ras_pop),
    .push_addr_i (ras_push_addr),
    .top_valid_o (ras_valid),
    .top_addr_o  (ras_addr)
  );

  fetch_ctrl i_fetch_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .imem_req_valid_o   (imem_req_valid_o),
    .imem_req_addr_o    (imem_req_addr_o),
    .imem_req_ready_i   (imem_req_ready_i),
    .imem_rsp_valid_i   (imem_rsp_valid_i),
    .imem_rsp_data_i    (imem_rsp_data_i),
    .cf_i               (scan_cf),
    .imm_i              (scan_imm),
    .bht_idx_o          (bht_idx),
    .bht_valid_i        (bht_valid),
    .bht_taken_i        (bht_taken),
    .ras_push_o         (ras_push),
    .ras_push_addr_o    (ras_push_addr),
    .ras_pop_o          (ras_pop),
    .ras_valid_i        (ras_valid),
    .ras_addr_i         (ras_addr),
    .redirect_valid_i   (redirect_valid_i),
    .redirect_pc_i      (redirect_pc_i),
    .fetch_valid_o      (fetch_valid_o),
    .fetch_pc_o         (fetch_pc_o),
    .fetch_instr_o      (fetch_instr_o),
    .fetch_pred_taken_o (fetch_pred_taken_o),
    .fetch_pred_pc_o    (fetch_pred_pc_o),
    .fetch_ready_i      (fetch_ready_i)
  );

endmodule : frontend

`default_nettype wire

// File: sim/frontend_props.sv
/*
 * Fetch control properties
 * Reset state, first request address, request hold and the
 * single outstanding memory request
 */
`default_nettype none

module frontend_props (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic                              imem_req_valid_o,
  input logic                              imem_req_ready_i,
  input logic [frontend_cfg_pkg::XLEN-1:0] imem_req_addr_o,
  input logic                              imem_rsp_valid_i,
  input logic                              fetch_valid_o,
  input logic                              redirect_valid_i
);

  import frontend_cfg_pkg::*;

  // one request accepted and not yet answered
  logic busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (imem_req_valid_o && imem_req_ready_i) begin
      busy_q <= 1'b1;
    end else if (imem_rsp_valid_i) begin
      busy_q <= 1'b0;
    end
  end

  // quiet outputs while in reset
  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !imem_req_valid_o && !fetch_valid_o)
    else $error("request or entry valid during reset");

  // first cycle out of reset fetches the boot address
  first_req: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> imem_req_valid_o && (imem_req_addr_o == RESET_PC))
    else $error("first request does not carry the reset address");

  // never a second request while one is pending
  one_in_flight: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_req_valid_o |-> !busy_q)
    else $error("request raised with a response still outstanding");

  rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_rsp_valid_i |-> busy_q)
    else $error("memory response without a request");

  // a stalled request keeps its address unless the back end redirects
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_req_valid_o && !imem_req_ready_i |=>
      redirect_valid_i || (imem_req_valid_o && $stable(imem_req_addr_o)))
    else $error("stalled request dropped or changed address");

endmodule : frontend_props

bind fetch_ctrl frontend_props i_frontend_props (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .imem_req_valid_o (imem_req_valid_o),
  .imem_req_ready_i (imem_req_ready_i),
  .imem_req_addr_o  (imem_req_addr_o),
  .imem_rsp_valid_i (imem_rsp_valid_i),
  .fetch_valid_o    (fetch_valid_o),
  .redirect_valid_i (redirect_valid_i)
);

`default_nettype wire

// File: sim/tb_frontend.sv
/*
 * Fetch frontend testbench
 * Random-latency memory, decode with back-pressure and scripted
 * branch outcomes, and a reference predictor checked per entry
 */
`default_nettype none

module tb_frontend;

  import frontend_cfg_pkg::*;
  import riscv_cf_pkg::*;

  localparam int unsigned N_ENTRIES = 600;

  logic clk_i, rst_ni;
  logic imem_req_valid_o, imem_req_ready_i, imem_rsp_valid_i;
  logic [XLEN-1:0] imem_req_addr_o, imem_rsp_data_i;
  logic fetch_valid_o, fetch_pred_taken_o, fetch_ready_i;
  logic [XLEN-1:0] fetch_pc_o, fetch_instr_o, fetch_pred_pc_o;
  logic redirect_valid_i, resolve_valid_i, resolve_taken_i;
  logic [XLEN-1:0] redirect_pc_i, resolve_pc_i;

  integer seed = 23524;
  int errors = 0;
  int checks = 0;
  int transfers = 0;
  int mispredicts = 0;

  logic [XLEN-1:0] prog [256];
  // memory model state
  logic            pending = 1'b0;
  logic            stale = 1'b0;
  logic [XLEN-1:0] rsp_addr;
  // pc the reference expects for the outstanding word
  logic [XLEN-1:0] rsp_pc;
  int              rsp_wait;
  // reference predictor
  logic [XLEN-1:0] exp_next_pc = RESET_PC;
  logic [XLEN-1:0] exp_pc_q [$];
  logic [XLEN-1:0] exp_pred_q [$];
  logic            exp_taken_q [$];
  logic [XLEN-1:0] ret_stack [$];
  logic            ref_valid [BHT_ENTRIES];
  logic [1:0]      ref_cnt [BHT_ENTRIES];
  logic [1:0]      visits [BHT_ENTRIES];
  // entry seen at the previous edge, for the hold check
  logic            hold_prev = 1'b0;
  logic [XLEN-1:0] prev_pc, prev_instr, prev_pred;
  logic            prev_taken;

  frontend uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [XLEN-1:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [XLEN-1:0] enc_branch(input logic [2:0] f3, input logic [12:0] off);
    return {off[12], off[10:5], 5'd0, 5'd0, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [XLEN-1:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'd0, rs1, 3'b000, rd, 7'h67};
  endfunction

  function automatic logic [XLEN-1:0] b_offset(input logic [XLEN-1:0] w);
    return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic logic [XLEN-1:0] j_offset(input logic [XLEN-1:0] w);
    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic logic is_link(input logic [4:0] r);
    return (r == REG_RA) || (r == REG_T0);
  endfunction

  task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic push_return(input logic [XLEN-1:0] addr);
    ret_stack.push_front(addr);
    // oldest entry falls off a full stack
    if (ret_stack.size() > RAS_DEPTH) begin
      void'(ret_stack.pop_back());
    end
  endtask

  // expected entry for one live response word
  task automatic predict(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] w);
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [3:0]      idx;
    logic            taken;
    logic [XLEN-1:0] pred;
    rd    = w[11:7];
    rs1   = w[19:15];
    idx   = pc[5:2];
    taken = 1'b0;
    pred  = pc + 32'd4;
    case (w[6:0])
      7'h63: begin
        // trained counter, else backward taken
        taken = ref_valid[idx] ? ref_cnt[idx][1] : w[31];
        if (taken) pred = pc + b_offset(w);
      end
      7'h6f: begin
        taken = 1'b1;
        pred  = pc + j_offset(w);
        if (is_link(rd)) push_return(pc + 32'd4);
      end
      7'h67: begin
        if (is_link(rd)) begin
          push_return(pc + 32'd4);
        end else if (is_link(rs1) && (rd == 5'd0) && (ret_stack.size() > 0)) begin
          taken = 1'b1;
          pred  = ret_stack.pop_front();
        end
      end
      default: ;
    endcase
    exp_pc_q.push_back(pc);
    exp_pred_q.push_back(pred);
    exp_taken_q.push_back(taken);
    exp_next_pc = pred;
  endtask

  always @(posedge clk_i) begin : model
    logic            outcome;
    logic [3:0]      idx;
    logic [XLEN-1:0] exp_pc;
    if (!rst_ni) begin
      checks++;
      assert (!imem_req_valid_o && !fetch_valid_o) else begin
        errors++;
        $display("request or entry valid while reset is held");
      end
    end else begin
      // held entry must not move under back-pressure
      if (hold_prev && fetch_valid_o) begin
        check_word("hold_pc", prev_pc, fetch_pc_o);
        check_word("hold_instr", prev_instr, fetch_instr_o);
        check_word("hold_pred_pc", prev_pred, fetch_pred_pc_o);
        check_word("hold_taken", {31'd0, prev_taken}, {31'd0, fetch_pred_taken_o});
      end
      hold_prev  = fetch_valid_o && !fetch_ready_i;
      prev_pc    = fetch_pc_o;
      prev_instr = fetch_instr_o;
      prev_pred  = fetch_pred_pc_o;
      prev_taken = fetch_pred_taken_o;

      // decode side
      resolve_valid_i  <= 1'b0;
      redirect_valid_i <= 1'b0;
      fetch_ready_i    <= ($random(seed) & 3) != 0;
      if (fetch_valid_o && fetch_ready_i) begin
        transfers++;
        if (exp_pc_q.size() == 0) begin
          errors++;
          $display("entry at pc %h delivered with no live response behind it", fetch_pc_o);
        end else begin
          exp_pc = exp_pc_q.pop_front();
          check_word("entry_pc", exp_pc, fetch_pc_o);
          check_word("entry_instr", prog[exp_pc[9:2]], fetch_instr_o);
          check_word("pred_pc", exp_pred_q.pop_front(), fetch_pred_pc_o);
          check_word("pred_taken", {31'd0, exp_taken_q.pop_front()},
                     {31'd0, fetch_pred_taken_o});
        end
      end
      if (fetch_valid_o && fetch_ready_i && (fetch_instr_o[6:0] == 7'h63)) begin
        // scripted outcome, three taken then one not taken per slot
        idx     = fetch_pc_o[5:2];
        outcome = (visits[idx] != 2'd3);
        visits[idx] = visits[idx] + 2'd1;
        resolve_valid_i <= 1'b1;
        resolve_pc_i    <= fetch_pc_o;
        resolve_taken_i <= outcome;
        if (outcome != fetch_pred_taken_o) begin
          mispredicts++;
          redirect_valid_i <= 1'b1;
          redirect_pc_i    <= outcome ? fetch_pc_o + b_offset(fetch_instr_o)
                                      : fetch_pc_o + 32'd4;
        end
      end else if (($random(seed) & 63) == 0) begin
        // occasional trap-like redirect back to the boot code
        redirect_valid_i <= 1'b1;
        redirect_pc_i    <= RESET_PC;
      end

      // memory side
      imem_req_ready_i <= ($random(seed) & 1) != 0;
      if (imem_rsp_valid_i) begin
        imem_rsp_valid_i <= 1'b0;
        pending = 1'b0;
        if (!stale && !redirect_valid_i) predict(rsp_pc, imem_rsp_data_i);
      end else if (pending) begin
        if (rsp_wait == 0) begin
          imem_rsp_valid_i <= 1'b1;
          imem_rsp_data_i  <= prog[rsp_addr[9:2]];
        end else begin
          rsp_wait--;
        end
      end
      if (redirect_valid_i) begin
        stale = pending;
        exp_pc_q.delete();
        exp_pred_q.delete();
        exp_taken_q.delete();
        exp_next_pc = redirect_pc_i;
      end
      if (imem_req_valid_o && imem_req_ready_i) begin
        check_word("req_addr", exp_next_pc, imem_req_addr_o);
        rsp_addr = imem_req_addr_o;
        rsp_pc   = exp_next_pc;
        pending  = 1'b1;
        stale    = 1'b0;
        rsp_wait = $random(seed) & 3;
      end

      // counters change after the lookups of this cycle
      if (resolve_valid_i) begin
        idx = resolve_pc_i[5:2];
        if (!ref_valid[idx]) begin
          ref_cnt[idx] = resolve_taken_i ? 2'd2 : 2'd1;
        end else if (resolve_taken_i && (ref_cnt[idx] != 2'd3)) begin
          ref_cnt[idx] = ref_cnt[idx] + 2'd1;
        end else if (!resolve_taken_i && (ref_cnt[idx] != 2'd0)) begin
          ref_cnt[idx] = ref_cnt[idx] - 2'd1;
        end
        ref_valid[idx] = 1'b1;
      end
    end
  end

  initial begin : main
    int cycles;
    rst_ni           = 1'b0;
    imem_req_ready_i = 1'b0;
    imem_rsp_valid_i = 1'b0;
    imem_rsp_data_i  = '0;
    fetch_ready_i    = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    resolve_valid_i  = 1'b0;
    resolve_pc_i     = '0;
    resolve_taken_i  = 1'b0;
    for (int i = 0; i < BHT_ENTRIES; i++) begin
      ref_valid[i] = 1'b0;
      ref_cnt[i]   = 2'd0;
      visits[i]    = 2'd0;
    end
    // addi x0, x0, index everywhere
    for (int i = 0; i < 256; i++) begin
      prog[i] = {4'h0, i[7:0], 20'h00013};
    end
    // nested calls, returns, a loop branch, a forward branch, an empty-stack return
    prog[32'h84 >> 2] = enc_jal(REG_RA, 21'h20);
    prog[32'ha4 >> 2] = enc_jal(REG_RA, 21'h20);
    prog[32'hc4 >> 2] = enc_jalr(5'd0, REG_RA);
    prog[32'ha8 >> 2] = enc_jalr(5'd0, REG_RA);
    prog[32'h88 >> 2] = enc_branch(3'b000, -13'sd8);
    prog[32'h8c >> 2] = enc_branch(3'b001, 13'd16);
    prog[32'h90 >> 2] = enc_jalr(5'd0, REG_T0);
    prog[32'h94 >> 2] = enc_jal(5'd0, -21'sd20);

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    cycles = 0;
    while ((transfers < N_ENTRIES) && (cycles < 50000)) begin
      @(posedge clk_i);
      cycles++;
    end
    if (transfers < N_ENTRIES) begin
      errors++;
      $display("timed out waiting for entries, only %0d reached decode", transfers);
    end
    $display("checks %0d errors %0d entries %0d mispredicts %0d",
             checks, errors, transfers, mispredicts);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_frontend

`default_nettype wire

// File: list.f
hdl/frontend_cfg_pkg.sv
hdl/riscv_cf_pkg.sv
hdl/instr_scan.sv
hdl/bht.sv
hdl/ras.sv
hdl/fetch_ctrl.sv
hdl/frontend.sv
sim/frontend_props.sv
sim/tb_frontend.sv

// File: Makefile
SRCS := $(shell cat list.f)

.PHONY: all run clean

all: run

# simulator binary, rebuilt only when a source or the file list changes
obj_dir/V%: list.f $(SRCS)
	verilator --binary --assert --timing -Wno-fatal -f list.f --top-module $* --Mdir obj_dir -o V$*

run: obj_dir/Vtb_frontend
	@out="$$(./obj_dir/Vtb_frontend)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
